//--- hdl/osiris_pkg.sv
/*
 * Osiris decode/execute shared types
 * Opcode, ALU and mux encodings plus the pipeline stage bundles
 */
package osiris_pkg;

    // Default data width for the whole slice
    localparam int XLEN_DEF = 32;

    // ------------------------------
    // Encodings
    // ------------------------------

    // Instruction bits 6:2
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011
    } opcode_e;

    // Class handed from the main decoder to the ALU decoder
    typedef enum logic [2:0] {
        ALU_OP_ADD       = 3'd0,
        ALU_OP_SUB       = 3'd1,
        ALU_OP_FUNCT     = 3'd2,
        ALU_OP_FUNCT_IMM = 3'd3,
        ALU_OP_BRANCH    = 3'd4,
        ALU_OP_PASS_B    = 3'd5
    } alu_op_e;

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_SEQ    = 5'd10,
        ALU_SGE    = 5'd11,
        ALU_SGEU   = 5'd12,
        ALU_PASS_B = 5'd13
    } alu_ctrl_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_src_e;

    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_e;

    typedef enum logic [1:0] {
        RES_ALU      = 2'd0,
        RES_MEM      = 2'd1,
        RES_PC_PLUS4 = 2'd2
    } result_src_e;

    // ------------------------------
    // Stage bundles
    // ------------------------------

    // Decoded control, all zero means no-op
    typedef struct packed {
        logic        jump;
        logic        branch;
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        logic        alu_src_imm;
        src_a_e      src_a;
        logic        addr_src_rs1;
        alu_ctrl_e   alu_ctrl;
        logic        fence;
    } id_ctrl_t;

    typedef struct packed {
        logic                valid;
        logic [31:0]         instr;
        logic [XLEN_DEF-1:0] pc;
        logic [XLEN_DEF-1:0] rs1_data;
        logic [XLEN_DEF-1:0] rs2_data;
    } if_id_t;

    typedef struct packed {
        logic                valid;
        id_ctrl_t            ctrl;
        logic [XLEN_DEF-1:0] pc;
        logic [XLEN_DEF-1:0] rs1_data;
        logic [XLEN_DEF-1:0] rs2_data;
        logic [XLEN_DEF-1:0] imm;
        logic [4:0]          rd;
    } id_ex_t;

    // EX results as seen by the downstream memory/writeback stages
    typedef struct packed {
        logic                valid;
        logic [XLEN_DEF-1:0] alu_result;
        logic [XLEN_DEF-1:0] pc_plus4;
        logic [XLEN_DEF-1:0] store_data;
        logic [4:0]          rd;
        logic                reg_write;
        logic                mem_write;
        result_src_e         result_src;
        logic                fence;
    } ex_out_t;

endpackage

//--- hdl/if_id_reg.sv
/*
 * IF/ID pipeline register
 * Captures instruction, PC and operands, bubble on flush or idle input
 */
module if_id_reg import osiris_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_flush,
    input  if_id_t i_d,
    output if_id_t o_q
);

    // Control part
    logic                valid_q;
    // Payload part
    logic [31:0]         instr_q;
    logic [XLEN_DEF-1:0] pc_q;
    logic [XLEN_DEF-1:0] rs1_q;
    logic [XLEN_DEF-1:0] rs2_q;

    // Flush wins over a valid input
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_d.valid & ~i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        instr_q <= i_d.instr;
        pc_q    <= i_d.pc;
        rs1_q   <= i_d.rs1_data;
        rs2_q   <= i_d.rs2_data;
    end

    assign o_q = '{valid: valid_q, instr: instr_q, pc: pc_q, rs1_data: rs1_q, rs2_data: rs2_q};

endmodule

//--- hdl/op_decoder.sv
/*
 * Main decoder
 * Opcode to control bits, immediate format and ALU class
 */
module op_decoder import osiris_pkg::*; (
    input  opcode_e  i_op,
    output id_ctrl_t o_ctrl,
    output imm_src_e o_imm_src,
    output alu_op_e  o_alu_op
);

    always_comb begin
        // Unknown opcodes fall through as a no-op
        o_ctrl    = '0;
        o_imm_src = IMM_I;
        o_alu_op  = ALU_OP_ADD;

        case (i_op)
            OPC_LOAD: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.result_src  = RES_MEM;
                o_ctrl.alu_src_imm = 1'b1;
            end
            OPC_STORE: begin
                o_ctrl.mem_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_imm_src          = IMM_S;
            end
            OPC_OP_IMM: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_alu_op           = ALU_OP_FUNCT_IMM;
            end
            OPC_OP: begin
                o_ctrl.reg_write = 1'b1;
                o_alu_op         = ALU_OP_FUNCT;
            end
            OPC_BRANCH: begin
                // Compare rs1 against rs2, target from PC + imm
                o_ctrl.branch = 1'b1;
                o_imm_src     = IMM_B;
                o_alu_op      = ALU_OP_BRANCH;
            end
            OPC_JAL: begin
                o_ctrl.jump       = 1'b1;
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.result_src = RES_PC_PLUS4;
                o_imm_src         = IMM_J;
            end
            OPC_JALR: begin
                o_ctrl.jump         = 1'b1;
                o_ctrl.reg_write    = 1'b1;
                o_ctrl.result_src   = RES_PC_PLUS4;
                o_ctrl.addr_src_rs1 = 1'b1;
            end
            OPC_LUI: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.src_a       = SRC_A_ZERO;
                o_imm_src          = IMM_U;
                o_alu_op           = ALU_OP_PASS_B;
            end
            OPC_AUIPC: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.src_a       = SRC_A_PC;
                o_imm_src          = IMM_U;
            end
            OPC_MISC_MEM: begin
                // FENCE only raises its flag
                o_ctrl.fence = 1'b1;
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

//--- hdl/alu_decoder.sv
/*
 * ALU decoder
 * ALU class plus funct fields to an ALU operation code
 */
module alu_decoder import osiris_pkg::*; (
    input  alu_op_e    i_alu_op,
    input  logic [2:0] i_funct_3,
    input  logic       i_funct_7_5,
    input  logic       i_op_5,
    output alu_ctrl_e  o_alu_ctrl
);

    always_comb begin
        case (i_alu_op)
            ALU_OP_ADD:    o_alu_ctrl = ALU_ADD;
            ALU_OP_SUB:    o_alu_ctrl = ALU_SUB;
            ALU_OP_PASS_B: o_alu_ctrl = ALU_PASS_B;
            ALU_OP_FUNCT, ALU_OP_FUNCT_IMM: begin
                case (i_funct_3)
                    // SUB only for register type, ADDI keeps bit 30 as imm
                    3'b000:  o_alu_ctrl = (i_op_5 && i_funct_7_5) ? ALU_SUB : ALU_ADD;
                    3'b001:  o_alu_ctrl = ALU_SLL;
                    3'b010:  o_alu_ctrl = ALU_SLT;
                    3'b011:  o_alu_ctrl = ALU_SLTU;
                    3'b100:  o_alu_ctrl = ALU_XOR;
                    // SRA/SRAI alike
                    3'b101:  o_alu_ctrl = i_funct_7_5 ? ALU_SRA : ALU_SRL;
                    3'b110:  o_alu_ctrl = ALU_OR;
                    default: o_alu_ctrl = ALU_AND;
                endcase
            end
            ALU_OP_BRANCH: begin
                // Result is zero exactly when taken
                case (i_funct_3)
                    3'b001:  o_alu_ctrl = ALU_SEQ;
                    3'b100:  o_alu_ctrl = ALU_SGE;
                    3'b101:  o_alu_ctrl = ALU_SLT;
                    3'b110:  o_alu_ctrl = ALU_SGEU;
                    3'b111:  o_alu_ctrl = ALU_SLTU;
                    default: o_alu_ctrl = ALU_SUB;
                endcase
            end
            default: o_alu_ctrl = ALU_ADD;
        endcase
    end

endmodule

//--- hdl/control_unit.sv
/*
 * Control unit
 * Main and ALU decoders for ID, PC source resolution for EX
 */
module control_unit import osiris_pkg::*; (
    input  opcode_e    i_op,
    input  logic [2:0] i_funct_3,
    input  logic       i_funct_7_5,
    input  logic       i_branch_ex,
    input  logic       i_jump_ex,
    input  logic       i_zero,
    output id_ctrl_t   o_ctrl_id,
    output imm_src_e   o_imm_src_id,
    output logic       o_pc_src_ex
);

    id_ctrl_t  op_ctrl;
    alu_op_e   alu_op;
    alu_ctrl_e alu_ctrl;
    logic      op_5;

    // Instruction bit 5 separates OP from OP_IMM
    assign op_5 = i_op[3];

    op_decoder u_op_decoder (
        .i_op      (i_op),
        .o_ctrl    (op_ctrl),
        .o_imm_src (o_imm_src_id),
        .o_alu_op  (alu_op)
    );

    alu_decoder u_alu_decoder (
        .i_alu_op    (alu_op),
        .i_funct_3   (i_funct_3),
        .i_funct_7_5 (i_funct_7_5),
        .i_op_5      (op_5),
        .o_alu_ctrl  (alu_ctrl)
    );

    always_comb begin
        o_ctrl_id          = op_ctrl;
        o_ctrl_id.alu_ctrl = alu_ctrl;
    end

    // EX-stage redirect, bits are zero for a bubble
    assign o_pc_src_ex = (i_zero & i_branch_ex) | i_jump_ex;

endmodule

//--- hdl/imm_extend.sv
/*
 * Immediate extender
 * Assembles I, S, B, U and J immediates, sign-extended to XLEN
 */
module imm_extend import osiris_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic [31:0]     i_instr,
    input  imm_src_e        i_imm_src,
    output logic [XLEN-1:0] o_imm
);

    logic [31:0] imm_32;

    always_comb begin
        case (i_imm_src)
            IMM_I: imm_32 = {{20{i_instr[31]}}, i_instr[31:20]};
            IMM_S: imm_32 = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            // Branch offset, bit 0 implied zero
            IMM_B: imm_32 = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                             i_instr[11:8], 1'b0};
            IMM_U: imm_32 = {i_instr[31:12], 12'b0};
            IMM_J: imm_32 = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                             i_instr[30:21], 1'b0};
            default: imm_32 = '0;
        endcase
    end

    // Widen to XLEN keeping the sign
    assign o_imm = XLEN'($signed(imm_32));

endmodule

//--- hdl/id_ex_reg.sv
/*
 * ID/EX pipeline register
 * Holds the decoded instruction, bubble on reset, flush or idle input
 */
module id_ex_reg import osiris_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_flush,
    input  id_ex_t i_d,
    output id_ex_t o_q
);

    // ------------------------------
    // Control part
    // ------------------------------
    logic     valid_q;
    id_ctrl_t ctrl_q;
    logic     load;

    assign load = i_d.valid & ~i_flush;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
        end else if (load) begin
            valid_q <= 1'b1;
            ctrl_q  <= i_d.ctrl;
        end else begin
            // Bubble, all control low
            valid_q <= 1'b0;
            ctrl_q  <= '0;
        end
    end

    // ------------------------------
    // Payload part
    // ------------------------------
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] imm_q;
    logic [4:0]      rd_q;

    always_ff @(posedge i_clk) begin
        pc_q  <= i_d.pc;
        rs1_q <= i_d.rs1_data;
        rs2_q <= i_d.rs2_data;
        imm_q <= i_d.imm;
        rd_q  <= i_d.rd;
    end

    assign o_q = '{valid: valid_q, ctrl: ctrl_q, pc: pc_q, rs1_data: rs1_q,
                   rs2_data: rs2_q, imm: imm_q, rd: rd_q};

endmodule

//--- hdl/ex_stage.sv
/*
 * Execute stage
 * Operand select, ALU, zero flag and branch/jump target
 */
module ex_stage import osiris_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  id_ex_t          i_d,
    output ex_out_t         o_out,
    output logic            o_zero,
    output logic [XLEN-1:0] o_target
);

    localparam int SHW = $clog2(XLEN);

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_plus4;
    logic [SHW-1:0]  shamt;
    logic            lt_s;
    logic            lt_u;
    logic            eq;

    // Operand muxes
    always_comb begin
        case (i_d.ctrl.src_a)
            SRC_A_PC:   src_a = i_d.pc;
            SRC_A_ZERO: src_a = '0;
            default:    src_a = i_d.rs1_data;
        endcase
    end

    assign src_b = i_d.ctrl.alu_src_imm ? i_d.imm : i_d.rs2_data;
    // Low bits only for shifts
    assign shamt = src_b[SHW-1:0];

    assign lt_s = $signed(src_a) < $signed(src_b);
    assign lt_u = src_a < src_b;
    assign eq   = src_a == src_b;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (i_d.ctrl.alu_ctrl)
            ALU_ADD:    alu_res = src_a + src_b;
            ALU_SUB:    alu_res = src_a - src_b;
            ALU_SLL:    alu_res = src_a << shamt;
            ALU_SLT:    alu_res = XLEN'(lt_s);
            ALU_SLTU:   alu_res = XLEN'(lt_u);
            ALU_XOR:    alu_res = src_a ^ src_b;
            ALU_SRL:    alu_res = src_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(src_a) >>> shamt);
            ALU_OR:     alu_res = src_a | src_b;
            ALU_AND:    alu_res = src_a & src_b;
            // Inverted compares for BNE, BLT, BLTU
            ALU_SEQ:    alu_res = XLEN'(eq);
            ALU_SGE:    alu_res = XLEN'(!lt_s);
            ALU_SGEU:   alu_res = XLEN'(!lt_u);
            ALU_PASS_B: alu_res = src_b;
            default:    alu_res = '0;
        endcase
    end

    assign o_zero   = (alu_res == '0);
    assign pc_plus4 = i_d.pc + XLEN'(4);

    // JALR uses rs1 as base and drops bit 0
    assign o_target = i_d.ctrl.addr_src_rs1 ?
                      ((i_d.rs1_data + i_d.imm) & ~XLEN'(1)) : (i_d.pc + i_d.imm);

    assign o_out = '{valid: i_d.valid, alu_result: alu_res, pc_plus4: pc_plus4,
                     store_data: i_d.rs2_data, rd: i_d.rd,
                     reg_write: i_d.ctrl.reg_write, mem_write: i_d.ctrl.mem_write,
                     result_src: i_d.ctrl.result_src, fence: i_d.ctrl.fence};

endmodule

//--- hdl/osiris_id_ex.sv
/*
 * Osiris decode/execute slice
 * IF/ID register, ID decode, ID/EX register and EX with redirect flush
 */
module osiris_id_ex import osiris_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_valid,
    input  logic [31:0]     i_instr,
    input  logic [XLEN-1:0] i_pc,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_rs2_data,
    output ex_out_t         o_ex,
    output logic            o_pc_src,
    output logic [XLEN-1:0] o_pc_target
);

    if_id_t          if_id_d;
    if_id_t          if_id_q;
    opcode_e         op_id;
    id_ctrl_t        ctrl_id;
    imm_src_e        imm_src_id;
    logic [XLEN-1:0] imm_id;
    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;
    logic            zero_ex;
    logic            pc_src_ex;

    // ------------------------------
    // IF/ID
    // ------------------------------
    assign if_id_d = '{valid: i_valid, instr: i_instr, pc: i_pc,
                       rs1_data: i_rs1_data, rs2_data: i_rs2_data};

    // Taken redirect kills both younger instructions
    if_id_reg u_if_id_reg (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (pc_src_ex),
        .i_d     (if_id_d),
        .o_q     (if_id_q)
    );

    // ------------------------------
    // ID
    // ------------------------------
    assign op_id = opcode_e'(if_id_q.instr[6:2]);

    control_unit u_control_unit (
        .i_op         (op_id),
        .i_funct_3    (if_id_q.instr[14:12]),
        .i_funct_7_5  (if_id_q.instr[30]),
        .i_branch_ex  (id_ex_q.ctrl.branch),
        .i_jump_ex    (id_ex_q.ctrl.jump),
        .i_zero       (zero_ex),
        .o_ctrl_id    (ctrl_id),
        .o_imm_src_id (imm_src_id),
        .o_pc_src_ex  (pc_src_ex)
    );

    imm_extend #(.XLEN(XLEN)) u_imm_extend (
        .i_instr   (if_id_q.instr),
        .i_imm_src (imm_src_id),
        .o_imm     (imm_id)
    );

    assign id_ex_d = '{valid: if_id_q.valid, ctrl: ctrl_id, pc: if_id_q.pc,
                       rs1_data: if_id_q.rs1_data, rs2_data: if_id_q.rs2_data,
                       imm: imm_id, rd: if_id_q.instr[11:7]};

    id_ex_reg #(.XLEN(XLEN)) u_id_ex_reg (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (pc_src_ex),
        .i_d     (id_ex_d),
        .o_q     (id_ex_q)
    );

    // ------------------------------
    // EX
    // ------------------------------
    ex_stage #(.XLEN(XLEN)) u_ex_stage (
        .i_d      (id_ex_q),
        .o_out    (o_ex),
        .o_zero   (zero_ex),
        .o_target (o_pc_target)
    );

    assign o_pc_src = pc_src_ex;

endmodule

//--- dv/tb_clk_gen.sv
/*
 * Testbench clock and reset generator
 */
module tb_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

//--- dv/tb_osiris_id_ex.sv
/*
 * Testbench for the decode/execute slice
 * Random RV32I stream against a two-stage reference model
 */
module tb_osiris_id_ex import osiris_pkg::*; ();

    // Instruction kinds for the generator
    localparam int K_IDLE   = -1;
    localparam int K_OP     = 0;
    localparam int K_OP_IMM = 1;
    localparam int K_LOAD   = 2;
    localparam int K_STORE  = 3;
    localparam int K_LUI    = 4;
    localparam int K_AUIPC  = 5;
    localparam int K_FENCE  = 6;
    localparam int K_BRANCH = 7;
    localparam int K_JAL    = 8;
    localparam int K_JALR   = 9;

    // Expected EX output plus what to compare
    typedef struct packed {
        ex_out_t     ex;
        logic        pc_src;
        logic [31:0] target;
        logic        chk_alu;
        logic        chk_target;
        logic [3:0]  kind;
        logic [2:0]  f3;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    ex_out_t     dut_ex;
    logic        pc_src;
    logic [31:0] pc_target;

    // Model state, one entry per pipeline register
    if_id_t      model_if;
    expect_t     model_ex;
    logic [31:0] rng;
    int          fail_count;
    int          redirect_left;
    int          seen [10];
    int          seen_taken [8];
    int          seen_not [8];

    tb_clk_gen #(.PERIOD(8), .RST_CYCLES(3)) i_tb_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    osiris_id_ex #(.XLEN(XLEN_DEF)) i_osiris_id_ex (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_valid     (valid),
        .i_instr     (instr),
        .i_pc        (pc),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .o_ex        (dut_ex),
        .o_pc_src    (pc_src),
        .o_pc_target (pc_target)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            fail_count++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "stopped on first error");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped on timeout");
    endtask

    // RV32I integer op, SUB only for register form
    function automatic logic [31:0] int_op(input logic [2:0] f3, input logic alt,
                                           input logic is_reg, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = (is_reg && alt) ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic expect_t predict(input if_id_t s);
        expect_t     e;
        logic [31:0] ins;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic        taken;
        e = '0;
        ins = s.instr;
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        if (s.valid) begin
            e.ex.valid      = 1'b1;
            e.ex.pc_plus4   = s.pc + 32'd4;
            e.ex.store_data = s.rs2_data;
            e.ex.rd         = ins[11:7];
            e.f3            = f3;
            case (ins[6:0])
                7'b0110011: begin
                    e.kind = K_OP;
                    e.ex.reg_write = 1'b1;
                    e.ex.alu_result = int_op(f3, ins[30], 1'b1, s.rs1_data, s.rs2_data);
                    e.chk_alu = 1'b1;
                end
                7'b0010011: begin
                    e.kind = K_OP_IMM;
                    e.ex.reg_write = 1'b1;
                    e.ex.alu_result = int_op(f3, ins[30], 1'b0, s.rs1_data, imm_i);
                    e.chk_alu = 1'b1;
                end
                7'b0000011: begin
                    e.kind = K_LOAD;
                    e.ex.reg_write = 1'b1;
                    e.ex.result_src = RES_MEM;
                    e.ex.alu_result = s.rs1_data + imm_i;
                    e.chk_alu = 1'b1;
                end
                7'b0100011: begin
                    e.kind = K_STORE;
                    e.ex.mem_write = 1'b1;
                    e.ex.alu_result = s.rs1_data + imm_s;
                    e.chk_alu = 1'b1;
                end
                7'b0110111: begin
                    e.kind = K_LUI;
                    e.ex.reg_write = 1'b1;
                    e.ex.alu_result = imm_u;
                    e.chk_alu = 1'b1;
                end
                7'b0010111: begin
                    e.kind = K_AUIPC;
                    e.ex.reg_write = 1'b1;
                    e.ex.alu_result = s.pc + imm_u;
                    e.chk_alu = 1'b1;
                end
                7'b0001111: begin
                    e.kind = K_FENCE;
                    e.ex.fence = 1'b1;
                end
                7'b1100011: begin
                    case (f3)
                        3'b000:  taken = (s.rs1_data == s.rs2_data);
                        3'b001:  taken = (s.rs1_data != s.rs2_data);
                        3'b100:  taken = ($signed(s.rs1_data) < $signed(s.rs2_data));
                        3'b101:  taken = ($signed(s.rs1_data) >= $signed(s.rs2_data));
                        3'b110:  taken = (s.rs1_data < s.rs2_data);
                        default: taken = (s.rs1_data >= s.rs2_data);
                    endcase
                    e.kind = K_BRANCH;
                    e.pc_src = taken;
                    e.target = s.pc + imm_b;
                    e.chk_target = 1'b1;
                end
                7'b1101111: begin
                    e.kind = K_JAL;
                    e.ex.reg_write = 1'b1;
                    e.ex.result_src = RES_PC_PLUS4;
                    e.pc_src = 1'b1;
                    e.target = s.pc + imm_j;
                    e.chk_target = 1'b1;
                end
                default: begin
                    // JALR, the only other opcode generated
                    e.kind = K_JALR;
                    e.ex.reg_write = 1'b1;
                    e.ex.result_src = RES_PC_PLUS4;
                    e.pc_src = 1'b1;
                    e.target = (s.rs1_data + imm_i) & ~32'd1;
                    e.chk_target = 1'b1;
                end
            endcase
        end
        return e;
    endfunction

    // Random encoding within the format of one kind
    task automatic make_instr(input int kind, output if_id_t s);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [2:0]  bf3 [6];
        bf3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        draw(r0);
        draw(r1);
        draw(r2);
        draw(r3);
        draw(r4);
        s = '0;
        s.instr = r0;
        s.pc = {r1[31:2], 2'b00};
        s.rs1_data = r2;
        s.rs2_data = r3;
        s.valid = (kind != K_IDLE);
        case (kind)
            K_OP:     s.instr = {1'b0, r0[30], 5'b0, r0[24:12], r0[11:7], 7'b0110011};
            K_OP_IMM: s.instr = {r0[31:7], 7'b0010011};
            K_LOAD:   s.instr = {r0[31:15], 3'b010, r0[11:7], 7'b0000011};
            K_STORE:  s.instr = {r0[31:15], 3'b010, r0[11:7], 7'b0100011};
            K_LUI:    s.instr = {r0[31:7], 7'b0110111};
            K_AUIPC:  s.instr = {r0[31:7], 7'b0010111};
            K_FENCE:  s.instr = {4'b0000, 8'hff, 13'b0, 7'b0001111};
            K_BRANCH: begin
                s.instr = {r0[31:15], bf3[r4 % 6], r0[11:7], 7'b1100011};
                // Equal operands half the time so BEQ/BNE both resolve
                if (r4[8]) begin
                    s.rs2_data = s.rs1_data;
                end
            end
            K_JAL:    s.instr = {r0[31:7], 7'b1101111};
            K_JALR:   s.instr = {r0[31:15], 3'b000, r0[11:7], 7'b1100111};
            default:  s.valid = 1'b0;
        endcase
    endtask

    // ------------------------------
    // Output checks
    // ------------------------------
    task automatic check_out(input expect_t e);
        compare("o_ex.valid", e.ex.valid, dut_ex.valid);
        compare("o_pc_src", e.pc_src, pc_src);
        compare("o_ex.reg_write", e.ex.reg_write, dut_ex.reg_write);
        compare("o_ex.mem_write", e.ex.mem_write, dut_ex.mem_write);
        compare("o_ex.fence", e.ex.fence, dut_ex.fence);
        // Two bubbles behind every redirect
        if (redirect_left > 0) begin
            compare("o_ex.valid after redirect", 32'd0, dut_ex.valid);
            redirect_left--;
        end
        if (e.ex.valid) begin
            compare("o_ex.pc_plus4", e.ex.pc_plus4, dut_ex.pc_plus4);
            if (e.chk_alu) begin
                compare("o_ex.alu_result", e.ex.alu_result, dut_ex.alu_result);
            end
            if (e.ex.reg_write) begin
                compare("o_ex.result_src", e.ex.result_src, dut_ex.result_src);
                compare("o_ex.rd", e.ex.rd, dut_ex.rd);
            end
            if (e.ex.mem_write) begin
                compare("o_ex.store_data", e.ex.store_data, dut_ex.store_data);
            end
            if (e.chk_target) begin
                compare("o_pc_target", e.target, pc_target);
            end
            seen[e.kind]++;
            if (e.kind == K_BRANCH && e.pc_src) begin
                seen_taken[e.f3]++;
            end else if (e.kind == K_BRANCH) begin
                seen_not[e.f3]++;
            end
        end
        if (e.pc_src) begin
            redirect_left = 2;
        end
    endtask

    // One cycle, check then advance the model to the next rising edge
    task automatic step_cycle(input int kind);
        if_id_t nxt;
        logic   flush;
        @(negedge clk);
        check_out(model_ex);
        flush = model_ex.pc_src;
        make_instr(kind, nxt);
        if (flush || !rst_n) begin
            model_ex = '0;
            model_if = '0;
        end else begin
            model_ex = predict(model_if);
            model_if = nxt.valid ? nxt : '0;
        end
        valid    = nxt.valid;
        instr    = nxt.instr;
        pc       = nxt.pc;
        rs1_data = nxt.rs1_data;
        rs2_data = nxt.rs2_data;
    endtask

    function automatic logic branch_cov_done();
        logic done;
        done = 1'b1;
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3 && (seen_taken[f] == 0 || seen_not[f] == 0)) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    // Mostly the wanted kind, some idle cycles in between
    task automatic run_kind(input int kind, input int need);
        logic [31:0] r;
        int          t;
        t = 0;
        while (seen[kind] < need) begin
            if (t >= 400) begin
                fail_timeout($sformatf("instruction kind %0d", kind));
            end
            draw(r);
            step_cycle((r[2:0] == 3'd0) ? K_IDLE : kind);
            t++;
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [31:0] r;
        int          t;
        valid         = 1'b0;
        instr         = '0;
        pc            = '0;
        rs1_data      = '0;
        rs2_data      = '0;
        rng           = 32'h3066;
        fail_count    = 0;
        redirect_left = 0;
        model_if      = '0;
        model_ex      = '0;
        for (int k = 0; k < 10; k++) begin
            seen[k] = 0;
        end
        for (int f = 0; f < 8; f++) begin
            seen_taken[f] = 0;
            seen_not[f] = 0;
        end

        // Bubbles through reset and a few idle cycles after it
        t = 0;
        while (!rst_n) begin
            if (t >= 20) begin
                fail_timeout("reset release");
            end
            step_cycle(K_IDLE);
            t++;
        end
        repeat (4) step_cycle(K_IDLE);

        for (int k = K_OP; k <= K_JALR; k++) begin
            run_kind(k, 12);
        end

        // Every branch type both taken and not taken
        t = 0;
        while (!branch_cov_done()) begin
            if (t >= 2000) begin
                fail_timeout("branch outcome coverage");
            end
            step_cycle(K_BRANCH);
            t++;
        end

        // Free mix of all kinds
        repeat (400) begin
            draw(r);
            step_cycle((r[3:0] == 4'd0) ? K_IDLE : int'(r[31:4] % 10));
        end
        repeat (4) step_cycle(K_IDLE);

        if (fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- osiris_decode.f
hdl/osiris_pkg.sv
hdl/if_id_reg.sv
hdl/op_decoder.sv
hdl/alu_decoder.sv
hdl/control_unit.sv
hdl/imm_extend.sv
hdl/id_ex_reg.sv
hdl/ex_stage.sv
hdl/osiris_id_ex.sv
dv/tb_clk_gen.sv
dv/tb_osiris_id_ex.sv

//--- Bender.yml
package:
  name: osiris_decode

sources:
  # Shared types first
  - hdl/osiris_pkg.sv
  # Leaf blocks
  - hdl/if_id_reg.sv
  - hdl/op_decoder.sv
  - hdl/alu_decoder.sv
  - hdl/control_unit.sv
  - hdl/imm_extend.sv
  - hdl/id_ex_reg.sv
  - hdl/ex_stage.sv
  # Top level
  - hdl/osiris_id_ex.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_osiris_id_ex.sv
